// File: hdl/snake_pkg.sv
package snake_pkg;

    // snake geometry
    localparam int MAX_SEGMENTS = 10;
    localparam int START_LENGTH = 5;

    typedef logic signed [11:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // index 0 is the head
    typedef point_t [MAX_SEGMENTS-1:0] body_t;

    typedef logic [3:0] length_t;

    typedef struct packed {
        logic [1:0] red;
        logic [1:0] green;
        logic [1:0] blue;
    } color_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } buttons_t;

    typedef enum logic [1:0] {
        GS_IDLE,
        GS_READY,
        GS_RUN,
        GS_OVER
    } game_state_e;

    typedef enum logic [1:0] {
        DIR_RIGHT,
        DIR_LEFT,
        DIR_UP,
        DIR_DOWN
    } dir_e;

    localparam coord_t CELL    = 12'sd30;
    localparam coord_t START_X = 12'sd120;

    // circle tests on squared distance
    localparam int HIT_RADIUS_SQ  = 400;
    localparam int FOOD_RADIUS_SQ = 225;

    // head limits
    localparam coord_t X_LIMIT  = 12'sd375;
    localparam coord_t Y_TOP    = 12'sd225;
    localparam coord_t Y_BOTTOM = -12'sd275;

    // food limits
    localparam coord_t FOOD_X_LIMIT  = 12'sd360;
    localparam coord_t FOOD_Y_TOP    = 12'sd220;
    localparam coord_t FOOD_Y_BOTTOM = -12'sd275;

    // drawn field, exclusive
    localparam coord_t FIELD_X      = 12'sd375;
    localparam coord_t FIELD_TOP    = 12'sd220;
    localparam coord_t FIELD_BOTTOM = -12'sd275;

    // off screen, out of food limits
    localparam point_t PARK_POS = '{x: 12'sd1000, y: 12'sd1000};

    localparam coord_t RND_MIN = -12'sd500;
    localparam coord_t RND_MAX = 12'sd500;

    localparam color_t COLOR_SNAKE  = '{red: 2'b00, green: 2'b11, blue: 2'b00};
    localparam color_t COLOR_FOOD   = '{red: 2'b11, green: 2'b00, blue: 2'b00};
    localparam color_t COLOR_FIELD  = '{red: 2'b00, green: 2'b00, blue: 2'b00};
    localparam color_t COLOR_BORDER = '{red: 2'b11, green: 2'b11, blue: 2'b11};
    localparam color_t COLOR_OVER   = '{red: 2'b11, green: 2'b00, blue: 2'b00};

endpackage

// File: hdl/game_control.sv
module game_control #(
    parameter int STEP_CYCLES = 2 ** 24
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::buttons_t    buttons,
    input  logic                   hit,
    output snake_pkg::game_state_e state,
    output snake_pkg::dir_e        dir,
    output logic                   step
);
    import snake_pkg::*;

    localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

    logic             any_press;
    logic [CNT_W-1:0] step_cnt;

    assign any_press = buttons.left | buttons.right | buttons.up | buttons.down;

    // game and direction FSM
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= GS_IDLE;
            dir   <= DIR_RIGHT;
        end else begin
            case (state)
                GS_IDLE: begin
                    if (any_press) begin
                        state <= GS_READY;
                    end
                end
                GS_READY: begin
                    if (hit) begin
                        state <= GS_OVER;
                    end else if (any_press) begin
                        state <= GS_RUN;
                        if (buttons.left || buttons.right) begin
                            dir <= DIR_RIGHT;
                        end else if (buttons.up) begin
                            dir <= DIR_UP;
                        end else begin
                            dir <= DIR_DOWN;
                        end
                    end
                end
                GS_RUN: begin
                    if (hit) begin
                        state <= GS_OVER;
                    end else if (dir == DIR_RIGHT || dir == DIR_LEFT) begin
                        // only perpendicular turns, no reversal
                        if (buttons.up) begin
                            dir <= DIR_UP;
                        end else if (buttons.down) begin
                            dir <= DIR_DOWN;
                        end
                    end else begin
                        if (buttons.left) begin
                            dir <= DIR_LEFT;
                        end else if (buttons.right) begin
                            dir <= DIR_RIGHT;
                        end
                    end
                end
                default: begin
                    // over until reset
                    state <= GS_OVER;
                end
            endcase
        end
    end

    // step timer, idle outside run
    always_ff @(posedge CLK) begin
        if (RESET || state != GS_RUN) begin
            step_cnt <= '0;
            step     <= 1'b0;
        end else if (step_cnt == CNT_W'(STEP_CYCLES - 1)) begin
            step_cnt <= '0;
            step     <= 1'b1;
        end else begin
            step_cnt <= step_cnt + 1'b1;
            step     <= 1'b0;
        end
    end

endmodule

// File: hdl/snake_body.sv
module snake_body (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::game_state_e state,
    input  snake_pkg::dir_e        dir,
    input  logic                   step,
    input  logic                   eaten,
    output snake_pkg::body_t       body,
    output snake_pkg::length_t     length,
    output logic                   hit
);
    import snake_pkg::*;

    point_t next_head;
    logic   hit_next;

    // straight line to the left of the start head, tail folded on segment 4
    function automatic body_t start_body();
        body_t b;
        int    idx;
        for (int k = 0; k < MAX_SEGMENTS; k++) begin
            idx = (k < START_LENGTH) ? k : START_LENGTH - 1;
            b[k].x = START_X - coord_t'(idx * CELL);
            b[k].y = '0;
        end
        return b;
    endfunction

    always_comb begin
        next_head = body[0];
        case (dir)
            DIR_RIGHT: next_head.x = body[0].x + CELL;
            DIR_LEFT:  next_head.x = body[0].x - CELL;
            DIR_UP:    next_head.y = body[0].y + CELL;
            default:   next_head.y = body[0].y - CELL;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET || state == GS_IDLE || state == GS_READY) begin
            body <= start_body();
        end else if (step) begin
            body[0] <= next_head;
            for (int k = 1; k < MAX_SEGMENTS; k++) begin
                if (k < START_LENGTH || int'(length) > k) begin
                    body[k] <= body[k-1];
                end else begin
                    // inactive tail follows segment 3
                    body[k] <= body[START_LENGTH-2];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            length <= length_t'(START_LENGTH);
        end else if (eaten && length != length_t'(MAX_SEGMENTS)) begin
            length <= length + 1'b1;
        end
    end

    // walls and self
    always_comb begin
        hit_next = (body[0].x >= X_LIMIT) || (body[0].x <= -X_LIMIT) ||
                   (body[0].y >= Y_TOP) || (body[0].y <= Y_BOTTOM);
        for (int k = 1; k < MAX_SEGMENTS; k++) begin
            if (body[0] == body[k]) begin
                hit_next = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            hit <= 1'b0;
        end else begin
            hit <= hit_next;
        end
    end

endmodule

// File: hdl/food_unit.sv
module food_unit (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::game_state_e state,
    input  snake_pkg::point_t      head,
    output snake_pkg::point_t      food,
    output logic                   eaten
);
    import snake_pkg::*;

    coord_t rnd;
    logic   food_out;

    // free running, wraps after passing the top
    always_ff @(posedge CLK) begin
        if (RESET) begin
            rnd <= RND_MIN;
        end else if (rnd > RND_MAX) begin
            rnd <= RND_MIN;
        end else begin
            rnd <= rnd + 1'b1;
        end
    end

    assign food_out = (food.x > FOOD_X_LIMIT) || (food.x < -FOOD_X_LIMIT) ||
                      (food.y > FOOD_Y_TOP) || (food.y < FOOD_Y_BOTTOM);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            food  <= PARK_POS;
            eaten <= 1'b0;
        end else begin
            eaten <= 1'b0;
            case (state)
                GS_IDLE: begin
                    food <= PARK_POS;
                end
                GS_READY, GS_RUN: begin
                    if (head == food) begin
                        eaten  <= 1'b1;
                        food.x <= coord_t'((rnd % 11) * CELL);
                        food.y <= coord_t'((rnd % 8) * CELL);
                    end else if (food_out) begin
                        // parked or off field, place without a meal
                        food.x <= coord_t'((rnd % 16) * CELL);
                        food.y <= coord_t'((rnd % 11) * CELL);
                    end
                end
                default: begin
                    food <= food;
                end
            endcase
        end
    end

endmodule

// File: hdl/raster_scan.sv
module raster_scan #(
    parameter int H_PIXELS = 800,
    parameter int V_PIXELS = 600
) (
    input  logic              CLK,
    input  logic              RESET,
    output snake_pkg::point_t scan_pos,
    output logic              scan_start
);
    import snake_pkg::*;

    localparam int COL_W = $clog2(H_PIXELS);
    localparam int ROW_W = $clog2(V_PIXELS);

    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;

    // no blanking, frames run back to back
    always_ff @(posedge CLK) begin
        if (RESET) begin
            col <= '0;
            row <= '0;
        end else if (col == COL_W'(H_PIXELS - 1)) begin
            col <= '0;
            if (row == ROW_W'(V_PIXELS - 1)) begin
                row <= '0;
            end else begin
                row <= row + 1'b1;
            end
        end else begin
            col <= col + 1'b1;
        end
    end

    // centre origin, y grows upward
    assign scan_pos.x = coord_t'(col) - coord_t'(H_PIXELS / 2);
    assign scan_pos.y = coord_t'(V_PIXELS / 2) - coord_t'(row);
    assign scan_start = (col == '0) && (row == '0);

endmodule

// File: hdl/pixel_shader.sv
module pixel_shader (
    input  logic                   CLK,
    input  logic                   RESET,
    input  snake_pkg::point_t      scan_pos,
    input  logic                   scan_start,
    input  snake_pkg::game_state_e state,
    input  snake_pkg::body_t       body,
    input  snake_pkg::length_t     length,
    input  snake_pkg::point_t      food,
    output snake_pkg::point_t      pix_pos,
    output snake_pkg::color_t      pix_color,
    output logic                   frame_start
);
    import snake_pkg::*;

    logic   on_snake;
    logic   on_food;
    logic   in_field;
    color_t color_next;

    // wide enough for parked food far off screen
    function automatic int dist_sq(point_t a, point_t b);
        int dx;
        int dy;
        dx = int'(a.x) - int'(b.x);
        dy = int'(a.y) - int'(b.y);
        return dx * dx + dy * dy;
    endfunction

    always_comb begin
        on_snake = 1'b0;
        for (int k = 0; k < MAX_SEGMENTS; k++) begin
            if ((k < START_LENGTH || int'(length) > k) &&
                dist_sq(scan_pos, body[k]) < HIT_RADIUS_SQ) begin
                on_snake = 1'b1;
            end
        end
    end

    assign on_food  = dist_sq(scan_pos, food) < FOOD_RADIUS_SQ;
    assign in_field = (scan_pos.x > -FIELD_X) && (scan_pos.x < FIELD_X) &&
                      (scan_pos.y > FIELD_BOTTOM) && (scan_pos.y < FIELD_TOP);

    // priority: over, snake, food, field, border
    always_comb begin
        if (state == GS_OVER) begin
            color_next = COLOR_OVER;
        end else if (on_snake) begin
            color_next = COLOR_SNAKE;
        end else if (on_food) begin
            color_next = COLOR_FOOD;
        end else if (in_field) begin
            color_next = COLOR_FIELD;
        end else begin
            color_next = COLOR_BORDER;
        end
    end

    always_ff @(posedge CLK) begin
        pix_pos   <= scan_pos;
        pix_color <= color_next;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= scan_start;
        end
    end

endmodule

// File: hdl/snake_top.sv
module snake_top #(
    parameter int H_PIXELS    = 800,
    parameter int V_PIXELS    = 600,
    parameter int STEP_CYCLES = 2 ** 24
) (
    input  logic                CLK,
    input  logic                RESET,
    input  snake_pkg::buttons_t buttons,
    output snake_pkg::point_t   pix_pos,
    output snake_pkg::color_t   pix_color,
    output logic                frame_start,
    output logic                eaten,
    output logic                game_over,
    output snake_pkg::length_t  length
);
    import snake_pkg::*;

    game_state_e state;
    dir_e        dir;
    logic        step;
    logic        hit;
    body_t       body;
    point_t      food;
    point_t      scan_pos;
    logic        scan_start;

    assign game_over = (state == GS_OVER);

    game_control #(
        .STEP_CYCLES(STEP_CYCLES)
    ) game_control0 (
        .CLK    (CLK),
        .RESET  (RESET),
        .buttons(buttons),
        .hit    (hit),
        .state  (state),
        .dir    (dir),
        .step   (step)
    );

    snake_body snake_body0 (
        .CLK   (CLK),
        .RESET (RESET),
        .state (state),
        .dir   (dir),
        .step  (step),
        .eaten (eaten),
        .body  (body),
        .length(length),
        .hit   (hit)
    );

    food_unit food_unit0 (
        .CLK  (CLK),
        .RESET(RESET),
        .state(state),
        .head (body[0]),
        .food (food),
        .eaten(eaten)
    );

    raster_scan #(
        .H_PIXELS(H_PIXELS),
        .V_PIXELS(V_PIXELS)
    ) raster_scan0 (
        .CLK       (CLK),
        .RESET     (RESET),
        .scan_pos  (scan_pos),
        .scan_start(scan_start)
    );

    pixel_shader pixel_shader0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .scan_pos   (scan_pos),
        .scan_start (scan_start),
        .state      (state),
        .body       (body),
        .length     (length),
        .food       (food),
        .pix_pos    (pix_pos),
        .pix_color  (pix_color),
        .frame_start(frame_start)
    );

endmodule

// File: test/snake_model.svh
`ifndef SNAKE_MODEL_SVH
`define SNAKE_MODEL_SVH

// reference copy of the DUT registers, advanced once per clock
game_state_e m_state;
dir_e        m_dir;
int          m_step_cnt;
logic        m_step;
body_t       m_body;
int          m_length;
logic        m_hit;
int          m_rnd;
point_t      m_food;
logic        m_eaten;
int          m_col;
int          m_row;
point_t      m_pix_pos;
color_t      m_pix_color;
logic        m_frame_start;

function automatic point_t make_point(int x, int y);
    point_t p;
    p.x = coord_t'(x);
    p.y = coord_t'(y);
    return p;
endfunction

// head first, unused tail segments sit on the last start point
function automatic body_t initial_body();
    body_t b;
    for (int k = 0; k < MAX_SEGMENTS; k++) begin
        b[k] = make_point(0, 0);
    end
    b[0] = make_point(120, 0);
    b[1] = make_point(90, 0);
    b[2] = make_point(60, 0);
    b[3] = make_point(30, 0);
    return b;
endfunction

function automatic bit seg_active(int k, int len);
    return (k < START_LENGTH) || (len > k);
endfunction

function automatic int sq_dist(point_t a, point_t b);
    int dx;
    int dy;
    dx = int'(a.x) - int'(b.x);
    dy = int'(a.y) - int'(b.y);
    return dx * dx + dy * dy;
endfunction

function automatic color_t expected_color(point_t p, game_state_e st, body_t b, int len,
                                          point_t f);
    if (st == GS_OVER) begin
        return COLOR_OVER;
    end
    for (int k = 0; k < MAX_SEGMENTS; k++) begin
        if (seg_active(k, len) && sq_dist(p, b[k]) < HIT_RADIUS_SQ) begin
            return COLOR_SNAKE;
        end
    end
    if (sq_dist(p, f) < FOOD_RADIUS_SQ) begin
        return COLOR_FOOD;
    end
    if (p.x > -FIELD_X && p.x < FIELD_X && p.y > FIELD_BOTTOM && p.y < FIELD_TOP) begin
        return COLOR_FIELD;
    end
    return COLOR_BORDER;
endfunction

task automatic model_clock(input buttons_t b, input logic rst);
    game_state_e n_state;
    dir_e        n_dir;
    int          n_step_cnt;
    logic        n_step;
    body_t       n_body;
    logic        n_hit;
    point_t      n_food;
    logic        n_eaten;
    logic        press;
    point_t      head;
    int          dx;
    int          dy;
    press = b.left | b.right | b.up | b.down;
    head = m_body[0];

    n_state = m_state;
    n_dir = m_dir;
    if (m_state == GS_IDLE) begin
        if (press) n_state = GS_READY;
    end else if (m_state != GS_OVER && m_hit) begin
        n_state = GS_OVER;
    end else if (m_state == GS_READY && press) begin
        n_state = GS_RUN;
        n_dir = (b.left || b.right) ? DIR_RIGHT : (b.up ? DIR_UP : DIR_DOWN);
    end else if (m_state == GS_RUN && (m_dir == DIR_RIGHT || m_dir == DIR_LEFT)) begin
        if (b.up) n_dir = DIR_UP;
        else if (b.down) n_dir = DIR_DOWN;
    end else if (m_state == GS_RUN) begin
        if (b.left) n_dir = DIR_LEFT;
        else if (b.right) n_dir = DIR_RIGHT;
    end

    n_step = (m_state == GS_RUN) && (m_step_cnt == STEP_CYCLES - 1);
    n_step_cnt = (m_state == GS_RUN && !n_step) ? m_step_cnt + 1 : 0;

    n_body = m_body;
    if (m_state == GS_IDLE || m_state == GS_READY) begin
        n_body = initial_body();
    end else if (m_step) begin
        dx = 0;
        dy = 0;
        case (m_dir)
            DIR_RIGHT: dx = CELL;
            DIR_LEFT:  dx = -CELL;
            DIR_UP:    dy = CELL;
            default:   dy = -CELL;
        endcase
        n_body[0] = make_point(head.x + dx, head.y + dy);
        for (int k = 1; k < MAX_SEGMENTS; k++) begin
            n_body[k] = seg_active(k, m_length) ? m_body[k-1] : m_body[3];
        end
    end

    n_hit = (head.x >= X_LIMIT) || (head.x <= -X_LIMIT) ||
            (head.y >= Y_TOP) || (head.y <= Y_BOTTOM);
    for (int k = 1; k < MAX_SEGMENTS; k++) begin
        if (m_body[k] == head) n_hit = 1'b1;
    end

    n_food = m_food;
    n_eaten = 1'b0;
    if (m_state == GS_IDLE) begin
        n_food = PARK_POS;
    end else if (m_state != GS_OVER && head == m_food) begin
        n_eaten = 1'b1;
        n_food = make_point((m_rnd % 11) * CELL, (m_rnd % 8) * CELL);
    end else if (m_state != GS_OVER && (m_food.x > FOOD_X_LIMIT || m_food.x < -FOOD_X_LIMIT ||
                 m_food.y > FOOD_Y_TOP || m_food.y < FOOD_Y_BOTTOM)) begin
        n_food = make_point((m_rnd % 16) * CELL, (m_rnd % 11) * CELL);
    end

    // output stage sees the values of this cycle
    m_pix_pos = make_point(m_col - H_PIXELS / 2, V_PIXELS / 2 - m_row);
    m_pix_color = expected_color(m_pix_pos, m_state, m_body, m_length, m_food);
    m_frame_start = !rst && m_col == 0 && m_row == 0;

    if (rst || m_col == H_PIXELS - 1) begin
        m_row = (rst || m_row == V_PIXELS - 1) ? 0 : m_row + 1;
        m_col = 0;
    end else begin
        m_col = m_col + 1;
    end

    if (rst) begin
        m_state = GS_IDLE;
        m_dir = DIR_RIGHT;
        m_step_cnt = 0;
        m_step = 1'b0;
        m_body = initial_body();
        m_length = START_LENGTH;
        m_hit = 1'b0;
        m_rnd = RND_MIN;
        m_food = PARK_POS;
        m_eaten = 1'b0;
    end else begin
        m_state = n_state;
        m_dir = n_dir;
        m_step_cnt = n_step_cnt;
        m_step = n_step;
        m_body = n_body;
        if (m_eaten && m_length < MAX_SEGMENTS) m_length = m_length + 1;
        m_hit = n_hit;
        m_rnd = (m_rnd > RND_MAX) ? int'(RND_MIN) : m_rnd + 1;
        m_food = n_food;
        m_eaten = n_eaten;
    end
endtask

`endif

// File: test/tb_snake_top.sv
module tb_snake_top;
    import snake_pkg::*;

    localparam int H_PIXELS     = 800;
    localparam int V_PIXELS     = 600;
    localparam int STEP_CYCLES  = 64;
    localparam int FRAME_CYCLES = H_PIXELS * V_PIXELS;
    localparam point_t FIRST_PIXEL = '{x: coord_t'(-H_PIXELS / 2), y: coord_t'(V_PIXELS / 2)};

    logic     CLK;
    logic     RESET;
    buttons_t buttons;
    point_t   pix_pos;
    color_t   pix_color;
    logic     frame_start;
    logic     eaten;
    logic     game_over;
    length_t  length;
    int       seed;

    `include "snake_model.svh"

    snake_top #(
        .H_PIXELS   (H_PIXELS),
        .V_PIXELS   (V_PIXELS),
        .STEP_CYCLES(STEP_CYCLES)
    ) dut0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .buttons    (buttons),
        .pix_pos    (pix_pos),
        .pix_color  (pix_color),
        .frame_start(frame_start),
        .eaten      (eaten),
        .game_over  (game_over),
        .length     (length)
    );

    always #2 CLK = ~CLK;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic compare_outputs();
        check("pix_pos", 32'(pix_pos), 32'(m_pix_pos));
        check("pix_color", 32'(pix_color), 32'(m_pix_color));
        check("frame_start", 32'(frame_start), 32'(m_frame_start));
        check("eaten", 32'(eaten), 32'(m_eaten));
        check("game_over", 32'(game_over), 32'(m_state == GS_OVER));
        check("length", 32'(length), 32'(m_length));
    endtask

    // one clock with the model after the edge, then compare and drive
    task automatic tick(input logic rst_level, input logic press_on);
        buttons_t b;
        @(posedge CLK);
        model_clock(buttons, RESET);
        #1;
        if (!RESET) begin
            compare_outputs();
        end
        b.left  = ($random(seed) % 50) == 0;
        b.right = ($random(seed) % 50) == 0;
        b.up    = ($random(seed) % 50) == 0;
        b.down  = ($random(seed) % 50) == 0;
        RESET = rst_level;
        buttons = (rst_level || !press_on) ? buttons_t'('0) : b;
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        tick(1'b0, 1'b1);
        while (frame_start !== 1'b1 && n < FRAME_CYCLES + 4) begin
            tick(1'b0, 1'b1);
            n++;
        end
        if (frame_start !== 1'b1) begin
            fail_run("timed out waiting for the start of a frame");
        end
        check("pix_pos", 32'(pix_pos), 32'(FIRST_PIXEL));
    endtask

    initial begin
        int cycles;
        CLK = 1'b0;
        RESET = 1'b1;
        buttons = '0;
        seed = 32'h2a00;
        for (int i = 0; i < 9; i++) begin
            tick(1'b1, 1'b0);
        end
        tick(1'b0, 1'b0);

        check("game_over", 32'(game_over), 32'd0);
        check("eaten", 32'(eaten), 32'd0);
        check("length", 32'(length), 32'd5);

        // a whole idle frame shows the start body and no food
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            tick(1'b0, 1'b0);
        end

        // play until the snake dies or six frames pass
        cycles = 0;
        while (!game_over && cycles < 6 * FRAME_CYCLES) begin
            tick(1'b0, 1'b1);
            cycles++;
        end
        if (game_over) begin
            wait_frame_start();
            wait_frame_start();
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// File: compile.f
+incdir+test
hdl/snake_pkg.sv
hdl/game_control.sv
hdl/snake_body.sv
hdl/food_unit.sv
hdl/raster_scan.sv
hdl/pixel_shader.sv
hdl/snake_top.sv
test/tb_snake_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the snake testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_snake_top; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_snake_top)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" <<< "$out"; then
    exit 0
else
    echo "pass message not found in simulation output"
    exit 1
fi
